// ==== design/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [63:0] counter_t;

    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Only machine and user mode exist
    typedef enum logic [1:0] {
        MODE_USER    = 2'b00,
        MODE_MACHINE = 2'b11
    } priv_mode_e;

    // Read-only counters
    localparam csr_addr_t CSR_ADDR_CYCLE      = 12'hC00;
    localparam csr_addr_t CSR_ADDR_CYCLEH     = 12'hC80;

    // Machine trap setup and handling
    localparam csr_addr_t CSR_ADDR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_ADDR_MIE        = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_ADDR_MCOUNTEREN = 12'h306;
    localparam csr_addr_t CSR_ADDR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE     = 12'h342;

    localparam int MSTATUS_MIE_BIT   = 3;
    localparam int MSTATUS_MPIE_BIT  = 7;
    localparam int MSTATUS_MPP_LSB   = 11;
    localparam int MIE_MTIE_BIT      = 7;
    localparam int MCOUNTEREN_CY_BIT = 0;

    localparam xlen_t MCAUSE_TIMER_INT  = 32'h8000_0007;
    // ECALL cause is this plus the current mode
    localparam xlen_t MCAUSE_ECALL_BASE = 32'd8;

endpackage

`default_nettype wire

// ==== design/csr_read_stage.sv ====
`default_nettype none

module csr_read_stage (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     flush,
    input  wire                     take_interrupt,
    input  wire csr_pkg::csr_cmd_e  csr_cmd,
    input  wire csr_pkg::csr_addr_t csr_addr,
    input  wire csr_pkg::xlen_t     op1_data,
    input  wire csr_pkg::counter_t  cycle_count,
    input  wire csr_pkg::priv_mode_e mode,
    input  wire                     mcounteren_cy,
    input  wire csr_pkg::xlen_t     read_data,
    output csr_pkg::csr_addr_t      read_addr,
    output csr_pkg::csr_cmd_e       cmd_out,
    output csr_pkg::csr_cmd_e       saved_cmd,
    output csr_pkg::csr_addr_t      saved_addr,
    output csr_pkg::xlen_t          saved_op1,
    output csr_pkg::xlen_t          rdata
);
    import csr_pkg::*;

    csr_cmd_e live_cmd;
    logic     counter_ok;

    // Flush turns the incoming command into a bubble
    assign live_cmd   = flush ? CSR_NONE : csr_cmd;
    // User mode sees the counters only when mcounteren.CY allows it
    assign counter_ok = (mode == MODE_MACHINE) || mcounteren_cy;
    assign read_addr  = csr_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_out   <= CSR_NONE;
            saved_cmd <= CSR_NONE;
            rdata     <= '0;
        end else begin
            if (take_interrupt) begin
                // Interrupt replaces the command, nothing gets written
                cmd_out   <= CSR_ECALL;
                saved_cmd <= CSR_NONE;
            end else begin
                cmd_out   <= live_cmd;
                saved_cmd <= live_cmd;
            end
            case (csr_addr)
                CSR_ADDR_CYCLE:  rdata <= counter_ok ? cycle_count[31:0] : '0;
                CSR_ADDR_CYCLEH: rdata <= counter_ok ? cycle_count[63:32] : '0;
                default:         rdata <= read_data;
            endcase
        end
    end

    // Operands for the write stage
    always_ff @(posedge clk) begin
        saved_addr <= csr_addr;
        saved_op1  <= op1_data;
    end

    a_cmd_out_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(cmd_out)
    );

endmodule

`default_nettype wire

// ==== design/csr_regs.sv ====
`default_nettype none

module csr_regs (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      wr_en,
    input  wire                      trap_en,
    input  wire csr_pkg::csr_addr_t  wr_addr,
    input  wire csr_pkg::csr_addr_t  read_addr,
    input  wire csr_pkg::xlen_t      wr_data,
    input  wire csr_pkg::xlen_t      mepc_next,
    input  wire csr_pkg::xlen_t      mcause_next,
    input  wire                      trap_kind,
    input  wire csr_pkg::priv_mode_e mpp_next,
    output csr_pkg::xlen_t           read_data,
    output csr_pkg::xlen_t           mtvec,
    output csr_pkg::xlen_t           mepc,
    output logic                     mstatus_mie,
    output logic                     mstatus_mpie,
    output logic                     mie_mtie,
    output logic                     mcounteren_cy,
    output csr_pkg::priv_mode_e      mstatus_mpp
);
    import csr_pkg::*;

    xlen_t mscratch;
    xlen_t mcause;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus_mie   <= 1'b0;
            mstatus_mpie  <= 1'b0;
            mstatus_mpp   <= MODE_MACHINE;
            mie_mtie      <= 1'b0;
            mcounteren_cy <= 1'b0;
            mtvec         <= '0;
            mscratch      <= '0;
            mepc          <= '0;
            mcause        <= '0;
        end else begin
            if (wr_en) begin
                case (wr_addr)
                    CSR_ADDR_MSTATUS: begin
                        mstatus_mie  <= wr_data[MSTATUS_MIE_BIT];
                        mstatus_mpie <= wr_data[MSTATUS_MPIE_BIT];
                        mstatus_mpp  <= priv_mode_e'(wr_data[MSTATUS_MPP_LSB +: 2]);
                    end
                    CSR_ADDR_MIE:        mie_mtie      <= wr_data[MIE_MTIE_BIT];
                    CSR_ADDR_MTVEC:      mtvec         <= wr_data;
                    CSR_ADDR_MCOUNTEREN: mcounteren_cy <= wr_data[MCOUNTEREN_CY_BIT];
                    CSR_ADDR_MSCRATCH:   mscratch      <= wr_data;
                    CSR_ADDR_MEPC:       mepc          <= wr_data;
                    CSR_ADDR_MCAUSE:     mcause        <= wr_data;
                    default: begin
                    end
                endcase
            end
            // Placed after the write so the trap update wins
            if (trap_en) begin
                mstatus_mpp <= mpp_next;
                if (trap_kind) begin
                    // MRET
                    mstatus_mie  <= mstatus_mpie;
                    mstatus_mpie <= 1'b1;
                end else begin
                    mstatus_mie  <= 1'b0;
                    mstatus_mpie <= mstatus_mie;
                    mepc         <= mepc_next;
                    mcause       <= mcause_next;
                end
            end
        end
    end

    always_comb begin
        read_data = '0;
        case (read_addr)
            CSR_ADDR_MSTATUS: begin
                read_data[MSTATUS_MIE_BIT]       = mstatus_mie;
                read_data[MSTATUS_MPIE_BIT]      = mstatus_mpie;
                read_data[MSTATUS_MPP_LSB +: 2]  = mstatus_mpp;
            end
            CSR_ADDR_MIE:        read_data[MIE_MTIE_BIT]      = mie_mtie;
            CSR_ADDR_MTVEC:      read_data                    = mtvec;
            CSR_ADDR_MCOUNTEREN: read_data[MCOUNTEREN_CY_BIT] = mcounteren_cy;
            CSR_ADDR_MSCRATCH:   read_data                    = mscratch;
            CSR_ADDR_MEPC:       read_data                    = mepc;
            CSR_ADDR_MCAUSE:     read_data                    = mcause;
            default: begin
            end
        endcase
    end

    // A write racing a trap into mstatus must not survive the edge
    a_trap_wins_mstatus: assert property (
        @(posedge clk) disable iff (!arst_n)
        trap_en && wr_en && wr_addr == CSR_ADDR_MSTATUS
        |=> mstatus_mpp == $past(mpp_next)
            && ($past(trap_kind) ? mstatus_mpie : !mstatus_mie)
    );

endmodule

`default_nettype wire

// ==== design/csr_stage.sv ====
`default_nettype none

module csr_stage (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire csr_pkg::csr_cmd_e csr_cmd,
    input  wire csr_pkg::csr_addr_t csr_addr,
    input  wire csr_pkg::xlen_t  op1_data,
    input  wire csr_pkg::xlen_t  fetch_pc,
    input  wire                  flush,
    input  wire                  interrupt_ready,
    input  wire csr_pkg::counter_t cycle_count,
    input  wire csr_pkg::counter_t mtime,
    input  wire csr_pkg::counter_t mtimecmp,
    output csr_pkg::csr_cmd_e    cmd_out,
    output csr_pkg::xlen_t       csr_rdata,
    output csr_pkg::xlen_t       trap_vector,
    output logic                 stall_may_interrupt
);
    import csr_pkg::*;

    csr_cmd_e   saved_cmd;
    csr_addr_t  saved_addr;
    xlen_t      saved_op1;
    csr_addr_t  read_addr;
    xlen_t      read_data;
    logic       wr_en;
    csr_addr_t  wr_addr;
    xlen_t      wr_data;
    logic       trap_en;
    logic       trap_kind;
    xlen_t      mepc_next;
    xlen_t      mcause_next;
    priv_mode_e mpp_next;
    priv_mode_e mode;
    priv_mode_e mstatus_mpp;
    logic       take_interrupt;
    logic       mstatus_mie;
    logic       mie_mtie;
    logic       mcounteren_cy;
    xlen_t      mtvec;
    xlen_t      mepc;

    // A flushed ECALL or MRET must not trap either
    wire csr_cmd_e trap_cmd = flush ? CSR_NONE : csr_cmd;

    csr_read_stage i_read_stage (
        .clk(clk), .arst_n(arst_n), .flush(flush), .take_interrupt(take_interrupt),
        .csr_cmd(csr_cmd), .csr_addr(csr_addr), .op1_data(op1_data),
        .cycle_count(cycle_count), .mode(mode), .mcounteren_cy(mcounteren_cy),
        .read_data(read_data), .read_addr(read_addr), .cmd_out(cmd_out),
        .saved_cmd(saved_cmd), .saved_addr(saved_addr), .saved_op1(saved_op1),
        .rdata(csr_rdata)
    );

    csr_write_stage i_write_stage (
        .saved_cmd(saved_cmd), .saved_addr(saved_addr), .saved_op1(saved_op1),
        .rdata(csr_rdata), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    csr_regs i_regs (
        .clk(clk), .arst_n(arst_n), .wr_en(wr_en), .trap_en(trap_en),
        .wr_addr(wr_addr), .read_addr(read_addr), .wr_data(wr_data),
        .mepc_next(mepc_next), .mcause_next(mcause_next), .trap_kind(trap_kind),
        .mpp_next(mpp_next), .read_data(read_data), .mtvec(mtvec), .mepc(mepc),
        .mstatus_mie(mstatus_mie), .mstatus_mpie(), .mie_mtie(mie_mtie),
        .mcounteren_cy(mcounteren_cy), .mstatus_mpp(mstatus_mpp)
    );

    csr_trap_unit i_trap_unit (
        .clk(clk), .arst_n(arst_n), .interrupt_ready(interrupt_ready),
        .csr_cmd(trap_cmd), .fetch_pc(fetch_pc), .mtvec(mtvec), .mepc(mepc),
        .mtime(mtime), .mtimecmp(mtimecmp), .mstatus_mie(mstatus_mie),
        .mie_mtie(mie_mtie), .mstatus_mpp(mstatus_mpp), .mode(mode),
        .take_interrupt(take_interrupt), .stall_may_interrupt(stall_may_interrupt),
        .trap_en(trap_en), .trap_kind(trap_kind), .mepc_next(mepc_next),
        .mcause_next(mcause_next), .trap_vector(trap_vector), .mpp_next(mpp_next)
    );

endmodule

`default_nettype wire

// ==== design/csr_trap_unit.sv ====
`default_nettype none

module csr_trap_unit (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      interrupt_ready,
    input  wire csr_pkg::csr_cmd_e   csr_cmd,
    input  wire csr_pkg::xlen_t      fetch_pc,
    input  wire csr_pkg::xlen_t      mtvec,
    input  wire csr_pkg::xlen_t      mepc,
    input  wire csr_pkg::counter_t   mtime,
    input  wire csr_pkg::counter_t   mtimecmp,
    input  wire                      mstatus_mie,
    input  wire                      mie_mtie,
    input  wire csr_pkg::priv_mode_e mstatus_mpp,
    output csr_pkg::priv_mode_e      mode,
    output logic                     take_interrupt,
    output logic                     stall_may_interrupt,
    output logic                     trap_en,
    output logic                     trap_kind,
    output csr_pkg::xlen_t           mepc_next,
    output csr_pkg::xlen_t           mcause_next,
    output csr_pkg::xlen_t           trap_vector,
    output csr_pkg::priv_mode_e      mpp_next
);
    import csr_pkg::*;

    logic interrupt_pending;
    logic trap_enter;
    logic do_mret;

    // Machine interrupts stay enabled in user mode regardless of MIE
    assign interrupt_pending = (mtime >= mtimecmp) && mie_mtie
                               && (mode == MODE_USER || mstatus_mie);
    assign stall_may_interrupt = interrupt_pending;
    assign take_interrupt      = interrupt_pending && interrupt_ready;

    assign trap_enter = take_interrupt || (csr_cmd == CSR_ECALL);
    assign do_mret    = !take_interrupt && (csr_cmd == CSR_MRET);

    assign trap_en   = trap_enter || do_mret;
    // 0 enters a trap, 1 returns from one
    assign trap_kind = do_mret;
    assign mepc_next = fetch_pc;
    assign mcause_next = take_interrupt ? MCAUSE_TIMER_INT
                                        : MCAUSE_ECALL_BASE + {30'b0, mode};
    // MPP records the old mode on entry, drops to user on MRET
    assign mpp_next  = do_mret ? MODE_USER : mode;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode        <= MODE_MACHINE;
            trap_vector <= '0;
        end else if (trap_enter) begin
            mode        <= MODE_MACHINE;
            trap_vector <= mtvec;
        end else if (do_mret) begin
            mode        <= mstatus_mpp;
            trap_vector <= mepc;
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_write_stage.sv ====
`default_nettype none

module csr_write_stage (
    input  wire csr_pkg::csr_cmd_e  saved_cmd,
    input  wire csr_pkg::csr_addr_t saved_addr,
    input  wire csr_pkg::xlen_t     saved_op1,
    input  wire csr_pkg::xlen_t     rdata,
    output logic                    wr_en,
    output csr_pkg::csr_addr_t      wr_addr,
    output csr_pkg::xlen_t          wr_data
);
    import csr_pkg::*;

    xlen_t raw_data;
    logic  is_update;
    logic  writable;

    // rdata is the value read one cycle earlier, i.e. the old CSR value
    always_comb begin
        case (saved_cmd)
            CSR_W:   raw_data = saved_op1;
            CSR_S:   raw_data = rdata | saved_op1;
            CSR_C:   raw_data = rdata & ~saved_op1;
            default: raw_data = '0;
        endcase
    end

    assign is_update = saved_cmd inside {CSR_W, CSR_S, CSR_C};

    // cycle and cycleh are not in this list
    assign writable = saved_addr inside {CSR_ADDR_MSTATUS, CSR_ADDR_MIE, CSR_ADDR_MTVEC,
                                         CSR_ADDR_MCOUNTEREN, CSR_ADDR_MSCRATCH,
                                         CSR_ADDR_MEPC, CSR_ADDR_MCAUSE};

    assign wr_en   = is_update && writable;
    assign wr_addr = saved_addr;

    always_comb begin
        wr_data = raw_data;
        case (saved_addr)
            CSR_ADDR_MSTATUS: begin
                // Only MIE, MPIE and MPP survive
                wr_data = '0;
                wr_data[MSTATUS_MIE_BIT]  = raw_data[MSTATUS_MIE_BIT];
                wr_data[MSTATUS_MPIE_BIT] = raw_data[MSTATUS_MPIE_BIT];
                // Unsupported MPP values fall back to user
                if (raw_data[MSTATUS_MPP_LSB +: 2] == MODE_MACHINE) begin
                    wr_data[MSTATUS_MPP_LSB +: 2] = MODE_MACHINE;
                end
            end
            CSR_ADDR_MTVEC: begin
                // Direct mode only, base is 4-byte aligned
                wr_data[1:0] = 2'b00;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/csr_pkg.sv
design/csr_read_stage.sv
design/csr_write_stage.sv
design/csr_regs.sv
design/csr_trap_unit.sv
design/csr_stage.sv
verification/csr_checker.sv
verification/tb_csr_stage.sv

// ==== verification/csr_checker.sv ====
`default_nettype none

module csr_checker (
    input  wire csr_pkg::csr_cmd_e cmd_out,
    input  wire csr_pkg::xlen_t    csr_rdata,
    input  wire csr_pkg::xlen_t    trap_vector,
    input  wire                    stall_may_interrupt,
    output int                     pass_count,
    output int                     fail_count
);
    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    // Expected mscratch contents
    xlen_t scratch_model;

    initial begin
        pass_count    = 0;
        fail_count    = 0;
        scratch_model = '0;
    end

    task automatic report_mismatch(input string name, input string field, input xlen_t exp,
                                   input xlen_t act);
        fail_count++;
        $display("[ERROR] %s: %s expected %h, actual %h", name, field, exp, act);
    endtask

    task automatic note_failure(input string what);
        fail_count++;
        $display("%s", what);
    endtask

    // Called once the command has been accepted, outputs are stable here
    task automatic check_test(input string name, input csr_cmd_e cmd, input xlen_t operand,
                              input int src, input bit flushed, input csr_cmd_e exp_cmd,
                              input xlen_t exp_rdata, input xlen_t exp_tvec,
                              input bit exp_stall);
        xlen_t want_rdata;
        want_rdata = (src != 0) ? scratch_model : exp_rdata;
        if (src != 0 && !flushed) begin
            case (cmd)
                CSR_W:   scratch_model = operand;
                CSR_S:   scratch_model = scratch_model | operand;
                CSR_C:   scratch_model = scratch_model & ~operand;
                default: begin
                end
            endcase
        end
        if (cmd_out !== exp_cmd) begin
            report_mismatch(name, "cmd_out", xlen_t'(exp_cmd), xlen_t'(cmd_out));
        end else if (csr_rdata !== want_rdata) begin
            report_mismatch(name, "csr_rdata", want_rdata, csr_rdata);
        end else if (trap_vector !== exp_tvec) begin
            report_mismatch(name, "trap_vector", exp_tvec, trap_vector);
        end else if (stall_may_interrupt !== exp_stall) begin
            report_mismatch(name, "stall_may_interrupt", xlen_t'(exp_stall),
                            xlen_t'(stall_may_interrupt));
        end else begin
            pass_count++;
            $display("[PASS] %s", name);
        end
    endtask

endmodule

`default_nettype wire

// ==== verification/csr_tests.txt ====
# name cmd addr op src pc cycles mtime mtimecmp flush irq exp_cmd exp_rdata exp_tvec exp_stall
# cmd 0-5: none w s c ecall mret; src 1: LCG operand; src 1 or 2: rdata from mscratch model
reset_mstatus      0 300 00000000 0 000 0         0   1  0 0 0 00001800 000 0
scratch_write      1 340 00000000 1 000 0         0   1  0 0 1 00000000 000 0
scratch_set        2 340 00000000 1 000 0         0   1  0 0 2 00000000 000 0
scratch_clear      3 340 00000000 1 000 0         0   1  0 0 3 00000000 000 0
scratch_read       0 340 00000000 2 000 0         0   1  0 0 0 00000000 000 0
mstatus_write_all  1 300 ffffffff 0 000 0         0   1  0 0 1 00001800 000 0
mstatus_legal      0 300 00000000 0 000 0         0   1  0 0 0 00001888 000 0
mtvec_write        1 305 00000103 0 000 0         0   1  0 0 1 00000000 000 0
mtvec_aligned      0 305 00000000 0 000 0         0   1  0 0 0 00000100 000 0
ecall_machine      4 000 00000000 0 200 0         0   1  0 0 4 00000000 100 0
mcause_machine     0 342 00000000 0 000 0         0   1  0 0 0 0000000b 100 0
mepc_machine       0 341 00000000 0 000 0         0   1  0 0 0 00000200 100 0
mpp_to_user        3 300 00001800 0 000 0         0   1  0 0 3 00001880 100 0
mret_to_user       5 000 00000000 0 000 0         0   1  0 0 5 00000000 200 0
cycle_blocked      0 c00 00000000 0 000 512345678 0   1  0 0 0 00000000 200 0
cy_enable          1 306 00000001 0 000 0         0   1  0 0 1 00000000 200 0
cycle_allowed      0 c00 00000000 0 000 512345678 0   1  0 0 0 12345678 200 0
ecall_user         4 000 00000000 0 300 0         0   1  0 0 4 00000000 100 0
mcause_user        0 342 00000000 0 000 0         0   1  0 0 0 00000008 100 0
mtie_enable        1 304 00000080 0 000 0         0   1  0 0 1 00000000 100 0
mtvec_handler      1 305 00000182 0 000 0         0   1  0 0 1 00000100 100 0
mie_enable         2 300 00000008 0 000 0         0   1  0 0 2 00000080 100 0
timer_pending      0 000 00000000 0 000 0         100 80 0 0 0 00000000 100 1
timer_taken        0 000 00000000 0 400 0         100 80 0 1 4 00000000 180 0
mcause_timer       0 342 00000000 0 000 0         100 80 0 0 0 80000007 180 0
mstatus_after_irq  0 300 00000000 0 000 0         0   1  0 0 0 00001880 180 0
flush_write        1 340 deadbeef 2 000 0         0   1  1 0 0 00000000 180 0
flush_check        0 340 00000000 2 000 0         0   1  0 0 0 00000000 180 0

// ==== verification/tb_csr_stage.sv ====
`default_nettype none

module tb_csr_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int WAIT_LIMIT = 20;
    localparam TEST_FILE = "verification/csr_tests.txt";

    logic        clk;
    logic        arst_n;
    csr_cmd_e    csr_cmd;
    csr_addr_t   csr_addr;
    xlen_t       op1_data;
    xlen_t       fetch_pc;
    logic        flush;
    logic        interrupt_ready;
    counter_t    cycle_count;
    counter_t    mtime;
    counter_t    mtimecmp;
    csr_cmd_e    cmd_out;
    xlen_t       csr_rdata;
    xlen_t       trap_vector;
    logic        stall_may_interrupt;
    int          pass_count;
    int          fail_count;
    int unsigned lcg_state;

    csr_stage i_dut (
        .clk(clk), .arst_n(arst_n), .csr_cmd(csr_cmd), .csr_addr(csr_addr),
        .op1_data(op1_data), .fetch_pc(fetch_pc), .flush(flush),
        .interrupt_ready(interrupt_ready), .cycle_count(cycle_count), .mtime(mtime),
        .mtimecmp(mtimecmp), .cmd_out(cmd_out), .csr_rdata(csr_rdata),
        .trap_vector(trap_vector), .stall_may_interrupt(stall_may_interrupt)
    );

    csr_checker i_checker (
        .cmd_out(cmd_out), .csr_rdata(csr_rdata), .trap_vector(trap_vector),
        .stall_may_interrupt(stall_may_interrupt), .pass_count(pass_count),
        .fail_count(fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Timers keep their values between tests
    task automatic drive_idle();
        csr_cmd         <= CSR_NONE;
        flush           <= 1'b0;
        interrupt_ready <= 1'b0;
    endtask

    task automatic run_line(input string line);
        string     name;
        int        cmd_num;
        int        exp_cmd_num;
        int        src;
        int        flush_num;
        int        irq_num;
        int        stall_num;
        int        fields;
        int        cycles;
        bit        seen;
        csr_addr_t addr;
        xlen_t     operand;
        xlen_t     pc;
        xlen_t     exp_rdata;
        xlen_t     exp_tvec;
        counter_t  count_v;
        counter_t  time_v;
        counter_t  cmp_v;
        fields = $sscanf(line, "%s %d %h %h %d %h %h %h %h %d %d %d %h %h %d", name, cmd_num,
                         addr, operand, src, pc, count_v, time_v, cmp_v, flush_num, irq_num,
                         exp_cmd_num, exp_rdata, exp_tvec, stall_num);
        if (fields != 15) begin
            i_checker.note_failure({"Malformed test line: ", line});
        end else begin
            if (src == 1) begin
                operand = next_random();
            end
            @(posedge clk);
            csr_cmd         <= csr_cmd_e'(cmd_num);
            csr_addr        <= addr;
            op1_data        <= operand;
            fetch_pc        <= pc;
            cycle_count     <= count_v;
            mtime           <= time_v;
            mtimecmp        <= cmp_v;
            flush           <= (flush_num != 0);
            interrupt_ready <= (irq_num != 0);
            // Idle inputs go out right after the accept edge
            cycles = 0;
            seen   = 1'b0;
            while (!seen && cycles < WAIT_LIMIT) begin
                @(posedge clk);
                drive_idle();
                @(negedge clk);
                cycles++;
                seen = !$isunknown(cmd_out);
            end
            if (seen) begin
                i_checker.check_test(name, csr_cmd_e'(cmd_num), operand, src, flush_num != 0,
                                     csr_cmd_e'(exp_cmd_num), exp_rdata, exp_tvec,
                                     stall_num != 0);
            end else begin
                i_checker.note_failure({"Test ", name, " timed out waiting for a known cmd_out"});
            end
        end
    endtask

    initial begin
        int    fd;
        int    status;
        string line;
        arst_n          = 1'b0;
        csr_cmd         = CSR_NONE;
        csr_addr        = '0;
        op1_data        = '0;
        fetch_pc        = '0;
        flush           = 1'b0;
        interrupt_ready = 1'b0;
        cycle_count     = '0;
        mtime           = '0;
        mtimecmp        = '1;
        lcg_state       = 32'd78;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open test file %s", TEST_FILE);
            $display("TESTBENCH FAILED");
        end else begin
            while (!$feof(fd)) begin
                line   = "";
                status = $fgets(line, fd);
                // Skip comments and blank lines
                if (status != 0 && line.len() > 3 && line.getc(0) != "#") begin
                    run_line(line);
                end
            end
            $fclose(fd);
            $display("Summary: %0d tests passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire
